//--- Bender.yml
package:
  name: arm_decode_stage

sources:
  - logic/arm_isa_pkg.sv
  - logic/pipe_ctrl_pkg.sv
  - logic/instr_decoder.sv
  - logic/cond_unit.sv
  - logic/id_ex_register.sv
  - logic/arm_decode_stage.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_arm_decode_stage.sv

//--- logic/arm_decode_stage.sv
`timescale 1ns/100ps

module arm_decode_stage
    import arm_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  instr_t instr,
    input  logic   instr_valid,
    input  flags_t flags_in,
    input  logic   flags_we,
    output ctrl_t  ex_ctrl,
    output logic   branch_taken
);

    ctrl_t dec_ctrl;   // Combinational decode
    logic  cond_pass;  // Condition check against current flags

    instr_decoder u_decoder (
        .instr    (instr),
        .dec_ctrl (dec_ctrl)
    );

    // Condition field is the top nibble of the word
    cond_unit u_cond (
        .clk       (clk),
        .rst_n     (rst_n),
        .cond      (instr[COND_MSB -: $bits(cond_t)]),
        .flags_in  (flags_in),
        .flags_we  (flags_we),
        .cond_pass (cond_pass)
    );

    id_ex_register u_id_ex (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_ctrl     (dec_ctrl),
        .instr_valid  (instr_valid),
        .cond_pass    (cond_pass),
        .ex_ctrl      (ex_ctrl),
        .branch_taken (branch_taken)
    );

endmodule

//--- logic/arm_isa_pkg.sv
package arm_isa_pkg;

    // Raw instruction word and its fields
    typedef logic [31:0] instr_t;
    typedef logic [3:0]  cond_t;         // Bits 31:28
    typedef logic [2:0]  instr_class_t;  // Bits 27:25
    typedef logic [3:0]  reg_idx_t;      // Register number
    typedef logic [11:0] imm12_t;        // Low field, immediate or shift spec

    // Field positions inside instr_t
    localparam int COND_MSB   = 31;  // Condition field top bit
    localparam int CLASS_LSB  = 25;  // Class field bottom bit
    localparam int OPCODE_LSB = 21;  // DP opcode, bits 24:21
    localparam int U_BIT      = 23;  // Up/down for load/store offset
    localparam int L_BIT      = 20;  // Load when set, store when clear
    localparam int LINK_BIT   = 24;  // BL versus B
    localparam int RD_LSB     = 12;  // Destination, bits 15:12

    // Instruction classes, bits 27:25
    localparam instr_class_t CLASS_DP_SHIFT = 3'b000;  // DP, shift by imm or reg
    localparam instr_class_t CLASS_DP_IMM   = 3'b001;  // DP, rotated immediate
    localparam instr_class_t CLASS_LS_IMM   = 3'b010;  // Load/store, imm offset
    localparam instr_class_t CLASS_LS_REG   = 3'b011;  // Load/store, reg offset
    localparam instr_class_t CLASS_BRANCH   = 3'b101;  // B and BL

    // Condition codes
    localparam cond_t COND_EQ = 4'b0000;  // Equal
    localparam cond_t COND_NE = 4'b0001;  // Not equal
    localparam cond_t COND_CS = 4'b0010;  // Carry set, unsigned higher or same
    localparam cond_t COND_CC = 4'b0011;  // Carry clear, unsigned lower
    localparam cond_t COND_MI = 4'b0100;  // Negative
    localparam cond_t COND_PL = 4'b0101;  // Positive or zero
    localparam cond_t COND_VS = 4'b0110;  // Overflow
    localparam cond_t COND_VC = 4'b0111;  // No overflow
    localparam cond_t COND_HI = 4'b1000;  // Unsigned higher
    localparam cond_t COND_LS = 4'b1001;  // Unsigned lower or same
    localparam cond_t COND_GE = 4'b1010;  // Signed greater or equal
    localparam cond_t COND_LT = 4'b1011;  // Signed less than
    localparam cond_t COND_GT = 4'b1100;  // Signed greater than
    localparam cond_t COND_LE = 4'b1101;  // Signed less or equal
    localparam cond_t COND_AL = 4'b1110;  // Always
    localparam cond_t COND_NV = 4'b1111;  // Never, treated as fail

endpackage

//--- logic/cond_unit.sv
`timescale 1ns/100ps

module cond_unit
    import arm_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  cond_t  cond,
    input  flags_t flags_in,
    input  logic   flags_we,
    output logic   cond_pass
);

    flags_t flags_q;  // Status register
    logic   n;
    logic   z;
    logic   c;
    logic   v;

    // Loaded from the ALU side when the S bit is set upstream
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            flags_q <= '0;
        else if (flags_we)
            flags_q <= flags_in;
    end

    assign n = flags_q[FLAG_N];
    assign z = flags_q[FLAG_Z];
    assign c = flags_q[FLAG_C];
    assign v = flags_q[FLAG_V];

    // Standard condition table
    always_comb
    begin
        cond_pass = 1'b0;
        case (cond)
            COND_EQ: cond_pass = z;
            COND_NE: cond_pass = ~z;
            COND_CS: cond_pass = c;
            COND_CC: cond_pass = ~c;
            COND_MI: cond_pass = n;
            COND_PL: cond_pass = ~n;
            COND_VS: cond_pass = v;
            COND_VC: cond_pass = ~v;
            COND_HI: cond_pass = c & ~z;
            COND_LS: cond_pass = ~c | z;
            COND_GE: cond_pass = (n == v);
            COND_LT: cond_pass = (n != v);
            COND_GT: cond_pass = ~z & (n == v);  // Both terms needed
            COND_LE: cond_pass = z | (n != v);
            COND_AL: cond_pass = 1'b1;
            COND_NV: cond_pass = 1'b0;           // Reserved space never issues
            default: cond_pass = 1'b0;
        endcase
    end

    // AL must issue regardless of flag contents
    a_al_passes: assert property (@(posedge clk) disable iff (!rst_n)
        (cond == COND_AL) |-> cond_pass)
        else $error("AL condition failed with flags %b", flags_q);

endmodule

//--- logic/id_ex_register.sv
`timescale 1ns/100ps

module id_ex_register
    import pipe_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  ctrl_t dec_ctrl,
    input  logic  instr_valid,
    input  logic  cond_pass,
    output ctrl_t ex_ctrl,
    output logic  branch_taken
);

    logic  issue;       // Instruction goes ahead this cycle
    ctrl_t issue_ctrl;

    assign issue = instr_valid & cond_pass;

    // Decoder leaves valid clear, stamp it here
    always_comb
    begin
        issue_ctrl       = dec_ctrl;
        issue_ctrl.valid = 1'b1;
    end

    // NOP mux folded into the stage register
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ex_ctrl      <= NOP_CTRL;
            branch_taken <= 1'b0;
        end
        else
        begin
            ex_ctrl      <= issue ? issue_ctrl : NOP_CTRL;
            branch_taken <= issue & dec_ctrl.branch;  // One pulse per taken branch
        end
    end

    // A taken branch is never a bubble
    a_branch_valid: assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken |-> ex_ctrl.valid)
        else $error("Branch pulse without a valid EX word");

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder
    import arm_isa_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  instr_t instr,
    output ctrl_t  dec_ctrl
);

    instr_class_t instr_class;
    logic         u_bit;
    logic         l_bit;
    logic         link_bit;
    alu_op_t      dp_opcode;

    // Field extraction
    assign instr_class = instr[CLASS_LSB +: $bits(instr_class_t)];
    assign u_bit       = instr[U_BIT];
    assign l_bit       = instr[L_BIT];
    assign link_bit    = instr[LINK_BIT];
    assign dp_opcode   = instr[OPCODE_LSB +: $bits(alu_op_t)];

    always_comb
    begin
        dec_ctrl = NOP_CTRL;  // Unknown classes stay a bubble

        // Operand fields pass through for every class
        dec_ctrl.rd    = instr[RD_LSB +: $bits(reg_idx_t)];
        dec_ctrl.imm12 = instr[$bits(imm12_t)-1:0];

        case (instr_class)
            CLASS_DP_SHIFT,
            CLASS_DP_IMM:
            begin
                dec_ctrl.rf_enable = 1'b1;
                dec_ctrl.alu_op    = dp_opcode;  // Opcode used as-is
                dec_ctrl.shift_imm = (instr_class == CLASS_DP_IMM);
            end

            CLASS_LS_IMM,
            CLASS_LS_REG:
            begin
                // Loads write Rd, stores write memory
                dec_ctrl.load_instr = l_bit;
                dec_ctrl.rf_enable  = l_bit;
                dec_ctrl.mem_write  = ~l_bit;
                dec_ctrl.alu_op     = u_bit ? ALU_OP_ADD : ALU_OP_SUB;  // Base +/- offset
                dec_ctrl.shift_imm  = (instr_class == CLASS_LS_IMM);
            end

            CLASS_BRANCH:
            begin
                dec_ctrl.branch    = 1'b1;
                dec_ctrl.link      = link_bit;
                dec_ctrl.rf_enable = link_bit;  // BL writes the link register
                dec_ctrl.alu_op    = link_bit ? ALU_OP_ADD : ALU_OP_NONE;
            end

            default:
            begin
                // Control bits stay clear
            end
        endcase
    end

    // Load and store are mutually exclusive
    a_ls_exclusive: assert final (!(dec_ctrl.mem_write && dec_ctrl.load_instr))
        else $error("Decoder drives both load and store for %h", instr);

endmodule

//--- logic/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

    // Status flags, N Z C V from the top
    typedef logic [3:0] flags_t;

    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // ALU opcode as seen by the EX stage
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_OP_NONE = 4'b0000;
    localparam alu_op_t ALU_OP_SUB  = 4'b0010;  // Load/store, U clear
    localparam alu_op_t ALU_OP_ADD  = 4'b0100;  // Load/store U set, BL return address

    // Decoded control word carried into EX
    // All-zero is a bubble
    typedef struct packed {
        logic                  valid;       // Set only by the ID/EX register
        logic                  shift_imm;   // Operand 2 from the immediate path
        logic                  rf_enable;   // Write back to Rd
        logic                  load_instr;  // Result comes from memory
        logic                  mem_write;   // Store
        logic                  branch;
        logic                  link;        // BL, writes return address
        alu_op_t               alu_op;
        arm_isa_pkg::reg_idx_t rd;
        arm_isa_pkg::imm12_t   imm12;
    } ctrl_t;

    localparam ctrl_t NOP_CTRL = '0;

endpackage

//--- sim.f
+incdir+verification
logic/arm_isa_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/instr_decoder.sv
logic/cond_unit.sv
logic/id_ex_register.sv
logic/arm_decode_stage.sv
verification/tb_arm_decode_stage.sv

//--- verification/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected control word for one instruction, valid left clear
function automatic ctrl_t model_decode(instr_t word);
    ctrl_t        c;
    instr_class_t cls;
    c     = '0;
    cls   = word[27:25];
    c.rd    = word[15:12];  // Always passed through
    c.imm12 = word[11:0];
    if (cls == CLASS_DP_SHIFT || cls == CLASS_DP_IMM)
    begin
        c.rf_enable = 1'b1;
        c.alu_op    = word[24:21];
        c.shift_imm = (cls == CLASS_DP_IMM);
    end
    else if (cls == CLASS_LS_IMM || cls == CLASS_LS_REG)
    begin
        c.load_instr = word[20];   // L bit
        c.rf_enable  = word[20];
        c.mem_write  = !word[20];
        c.alu_op     = word[23] ? ALU_OP_ADD : ALU_OP_SUB;  // U bit
        c.shift_imm  = (cls == CLASS_LS_IMM);
    end
    else if (cls == CLASS_BRANCH)
    begin
        c.branch    = 1'b1;
        c.link      = word[24];
        c.rf_enable = word[24];
        c.alu_op    = word[24] ? ALU_OP_ADD : ALU_OP_NONE;
    end
    return c;
endfunction

// Conditions come in pairs, odd code is the inverse of the even one
function automatic logic model_cond_pass(cond_t cond, flags_t f);
    logic n;
    logic z;
    logic c;
    logic v;
    logic base;
    {n, z, c, v} = f;  // N Z C V from the top
    case (cond[3:1])
        3'd0: base = z;                 // EQ / NE
        3'd1: base = c;                 // CS / CC
        3'd2: base = n;                 // MI / PL
        3'd3: base = v;                 // VS / VC
        3'd4: base = c && !z;           // HI / LS
        3'd5: base = (n == v);          // GE / LT
        3'd6: base = !z && (n == v);    // GT / LE
        default: base = 1'b1;           // AL
    endcase
    if (cond == 4'b1111)
        return 1'b0;  // NV never issues
    return cond[0] ? !base : base;
endfunction

`endif

//--- verification/tb_arm_decode_stage.sv
`timescale 1ns/100ps

module tb_arm_decode_stage
    import arm_isa_pkg::*;
    import pipe_ctrl_pkg::*;
;

    localparam int EDGE_POLL_LIMIT = 100;  // Polls of 1 ns cover well over one period

    logic   clk;
    logic   rst_n;
    instr_t instr;
    logic   instr_valid;
    flags_t flags_in;
    logic   flags_we;
    ctrl_t  ex_ctrl;
    logic   branch_taken;

    flags_t model_flags;     // Mirror of the DUT status register
    ctrl_t  exp_q[$];        // One entry in flight
    string  test_name;
    int     test_checks;
    int     test_errors;
    int     check_count;
    int     error_count;

    `include "decode_model.svh"

    arm_decode_stage i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .flags_in     (flags_in),
        .flags_we     (flags_we),
        .ex_ctrl      (ex_ctrl),
        .branch_taken (branch_taken)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Finished with errors");
        $finish;
    endtask

    // Polls on half-ns offsets so no poll lands on an edge
    // Returns at edge + 1 ns
    task automatic next_edge();
        int   polls;
        logic seen_low;
        polls    = 0;
        seen_low = 1'b0;
        #0.5;
        while (!(seen_low && clk))
        begin
            if (!clk)
                seen_low = 1'b1;
            if (polls == EDGE_POLL_LIMIT)
                abort_run("Timeout, no rising clock edge seen");
            #1;
            polls++;
        end
        #0.5;
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        test_checks++;
        if (expected !== actual)
        begin
            error_count++;
            test_errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("Test %-13s done, %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    function automatic instr_t rand_instr(cond_t c, instr_class_t cls);
        logic [31:0] r;
        r = $urandom;
        return {c, cls, r[24:0]};
    endfunction

    // Drives one cycle from edge + 2 ns
    // Result checked just after the next edge
    task automatic step(instr_t word, logic valid, flags_t new_flags, logic we);
        ctrl_t exp_ctrl;
        instr       = word;
        instr_valid = valid;
        flags_in    = new_flags;
        flags_we    = we;
        exp_ctrl    = NOP_CTRL;
        if (valid && model_cond_pass(word[31:28], model_flags))
        begin
            exp_ctrl       = model_decode(word);
            exp_ctrl.valid = 1'b1;
        end
        exp_q.push_back(exp_ctrl);
        if (we)
            model_flags = new_flags;  // Old flags used above
        next_edge();
        exp_ctrl = exp_q.pop_front();
        check_value({test_name, " ex_ctrl"}, exp_ctrl, ex_ctrl);
        check_value({test_name, " branch_taken"}, exp_ctrl.branch, branch_taken);
        #1;
    endtask

    initial
    begin
        int           i;
        int           c;
        flags_t       new_flags;
        instr_class_t cls;
        void'($urandom(99));
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        flags_in    = '0;
        flags_we    = 1'b0;
        model_flags = '0;
        check_count = 0;
        error_count = 0;

        begin_test("reset_state");
        repeat (8) next_edge();
        check_value("reset_state ex_ctrl", NOP_CTRL, ex_ctrl);
        check_value("reset_state branch_taken", 1'b0, branch_taken);
        #1;
        rst_n = 1'b1;
        // EQ, CS, MI and VS all fail while the flags are still clear
        for (i = 0; i < 4; i++)
            step(rand_instr(cond_t'(2 * i), CLASS_DP_IMM), 1'b1, '0, 1'b0);
        end_test();

        // Class cycles so all eight appear
        begin_test("decode");
        for (i = 0; i < 200; i++)
            step(rand_instr(COND_AL, instr_class_t'(i % 8)), 1'b1, flags_t'($urandom), 1'b0);
        end_test();

        // Flags written one cycle ahead of the checked word
        begin_test("cond_eval");
        for (c = 0; c < 16; c++)
        begin
            repeat (6)
            begin
                step(rand_instr(cond_t'($urandom), instr_class_t'($urandom)), 1'b0,
                     flags_t'($urandom), 1'b1);
                step(rand_instr(cond_t'(c), instr_class_t'($urandom)), 1'b1, '0, 1'b0);
            end
        end
        end_test();

        // Same-cycle word sees old flags and the next word sees new ones
        begin_test("flags_timing");
        for (i = 0; i < 40; i++)
        begin
            new_flags = model_flags ^ flags_t'($urandom_range(15, 1));
            step(rand_instr(cond_t'($urandom), instr_class_t'($urandom)), 1'b1, new_flags, 1'b1);
            step(rand_instr(cond_t'($urandom), instr_class_t'($urandom)), 1'b1, '0, 1'b0);
        end
        end_test();

        begin_test("branch_pulse");
        for (i = 0; i < 120; i++)
        begin
            cls = ($urandom % 2) ? CLASS_BRANCH : instr_class_t'($urandom);  // Mostly branches
            step(rand_instr(cond_t'($urandom), cls), 1'b1, flags_t'($urandom),
                 ($urandom % 3) == 0);
        end
        end_test();

        begin_test("invalid");
        for (i = 0; i < 60; i++)
            step(instr_t'($urandom), 1'b0, flags_t'($urandom), $urandom % 2);
        end_test();

        $display("Checks run %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
